// ==== vlog.f ====
hw/harness_pkg.sv
hw/debug_reset_ctrl.sv
hw/mem_decoder.sv
hw/boot_rom.sv
hw/sram.sv
hw/clint.sv
hw/soc_harness.sv
testbench/tb_soc_harness.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_soc_harness
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0

SOURCES   := $(shell cat $(FILELIST))
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_soc_harness.sv ====
// Testbench for the SoC harness
// ROM rule and shadow SRAM model, bus, CLINT and debug gate stimulus
// Responses and interrupts are checked by concurrent assertions
module tb_soc_harness;
  import harness_pkg::*;

  localparam int unsigned CLK_PERIOD  = 20;
  localparam int unsigned RST_CYCLES  = 10;
  localparam int unsigned SRAM_TESTS  = 8;
  localparam int unsigned TIMER_DELTA = 3;
  localparam int unsigned MAX_TICKS   = 10;
  localparam logic [DATA_WIDTH-1:0] MTIME_START = 64'd100;
  // Reset, debug hold-off and about 150 bus cycles, with margin
  localparam int unsigned RUN_CYCLES  = RST_CYCLES + DMI_DEL_CYCLES + 600;

  logic clk_i, rst_ni, rtc_i, ndmreset_i, debug_enable_i, debug_req_i, req_i, we_i;
  logic [ADDR_WIDTH-1:0] addr_i;
  logic [BE_WIDTH-1:0]   be_i;
  logic [DATA_WIDTH-1:0] wdata_i, rdata_o;
  logic rvalid_o, err_o, ipi_o, timer_irq_o, debug_req_o;

  logic                  sys_rst_n;
  logic                  exp_err;
  logic                  exp_chk;
  logic [DATA_WIDTH-1:0] exp_data;
  logic [DATA_WIDTH-1:0] shadow [SRAM_WORDS];
  int unsigned           sram_idx [SRAM_TESTS];
  int unsigned           por_cycles;
  int unsigned           rtc_rises;
  integer                seed = 18;

  soc_harness soc_harness_inst (.*);

  assign sys_rst_n = soc_harness_inst.sys_rst_n;

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Cycles since power-on reset, saturating at the debug hold-off
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      por_cycles <= 0;
    end else if (por_cycles < DMI_DEL_CYCLES) begin
      por_cycles <= por_cycles + 1;
    end
  end

  task automatic report_error(input string msg);
    $display("** Error at time %0t: %s", $time, msg);
    $display("test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  // ------------------------------
  // Checks
  // ------------------------------
  a_rvalid: assert property (@(posedge clk_i) disable iff (!sys_rst_n)
    $past(req_i) == rvalid_o) else report_error("rvalid_o does not follow the request");
  a_err: assert property (@(posedge clk_i) disable iff (!sys_rst_n)
    req_i |=> (err_o == $past(exp_err))) else report_error("wrong err_o in response");
  a_rdata: assert property (@(posedge clk_i) disable iff (!sys_rst_n)
    (req_i && exp_chk) |=> (rdata_o == $past(exp_data)))
    else report_error("wrong rdata_o in response");
  a_reset_quiet: assert property (@(posedge clk_i)
    !sys_rst_n |-> !(rvalid_o || err_o || ipi_o || timer_irq_o))
    else report_error("output active during system reset");
  a_ipi: assert property (@(posedge clk_i) disable iff (!sys_rst_n)
    (req_i && we_i && be_i[0] && addr_i == CLINT_BASE + MSIP_OFFSET)
    |=> (ipi_o == $past(wdata_i[0]))) else report_error("ipi_o does not follow MSIP write");
  a_timer_early: assert property (@(posedge clk_i) disable iff (!sys_rst_n)
    timer_irq_o |-> (rtc_rises >= TIMER_DELTA))
    else report_error("timer_irq_o raised before mtime reached mtimecmp");
  a_debug_gate: assert property (@(posedge clk_i) disable iff (!rst_ni)
    debug_req_o == (debug_enable_i && debug_req_i && por_cycles >= DMI_DEL_CYCLES))
    else report_error("wrong debug_req_o");

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] rom_expect(input logic [ADDR_WIDTH-1:0] addr);
    logic [ADDR_WIDTH-1:0] word;
    word = (addr - ROM_BASE) >> WORD_OFFSET_BITS;
    return {ROM_TAG, word[31:0] % 32'(ROM_WORDS)};
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] sram_addr(input int unsigned idx);
    return DRAM_BASE + (ADDR_WIDTH'(idx) << WORD_OFFSET_BITS);
  endfunction

  // One request per cycle, inputs change on the falling edge
  task automatic bus_access(input logic we, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [BE_WIDTH-1:0] be, input logic [DATA_WIDTH-1:0] wdata,
                            input logic [DATA_WIDTH-1:0] edata, input logic chk,
                            input logic err);
    req_i    = 1'b1;
    we_i     = we;
    addr_i   = addr;
    be_i     = be;
    wdata_i  = wdata;
    exp_data = edata;
    exp_chk  = chk;
    exp_err  = err;
    @(negedge clk_i);
  endtask

  task automatic bus_idle();
    req_i   = 1'b0;
    we_i    = 1'b0;
    exp_chk = 1'b0;
    exp_err = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic sram_write(input int unsigned idx, input logic [BE_WIDTH-1:0] be,
                            input logic [DATA_WIDTH-1:0] data);
    for (int b = 0; b < BE_WIDTH; b++) begin
      if (be[b]) begin
        shadow[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
    bus_access(1'b1, sram_addr(idx), be, data, '0, 1'b0, 1'b0);
  endtask

  task automatic sram_read(input int unsigned idx);
    bus_access(1'b0, sram_addr(idx), '1, '0, shadow[idx], 1'b1, 1'b0);
  endtask

  task automatic rtc_tick();
    rtc_i = 1'b1;
    rtc_rises = rtc_rises + 1;
    repeat (4) @(negedge clk_i);
    rtc_i = 1'b0;
    repeat (4) @(negedge clk_i);
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    logic [ADDR_WIDTH-1:0] addr;
    rst_ni = 1'b0;
    rtc_i = 1'b0;
    ndmreset_i = 1'b0;
    debug_enable_i = 1'b1;
    debug_req_i = 1'b1;
    req_i = 1'b0;
    we_i = 1'b0;
    addr_i = '0;
    be_i = '0;
    wdata_i = '0;
    exp_data = '0;
    exp_chk = 1'b0;
    exp_err = 1'b0;
    rtc_rises = 0;
    repeat (RST_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    wait (sys_rst_n);
    @(negedge clk_i);

    repeat (12) begin
      addr = ROM_BASE + (64'(rand32()) % ROM_LENGTH);
      bus_access(1'b0, addr, '1, '0, rom_expect(addr), 1'b1, 1'b0);
    end
    bus_access(1'b1, ROM_BASE, '1, {rand32(), rand32()}, '0, 1'b0, 1'b0);
    bus_idle();

    // Full words first so that partial writes never leave unknown bytes
    for (int i = 0; i < SRAM_TESTS; i++) begin
      sram_idx[i] = rand32() % SRAM_WORDS;
      sram_write(sram_idx[i], '1, {rand32(), rand32()});
    end
    repeat (16) sram_write(sram_idx[rand32() % SRAM_TESTS], BE_WIDTH'(rand32()),
                           {rand32(), rand32()});
    for (int i = 0; i < SRAM_TESTS; i++) sram_read(sram_idx[i]);
    bus_idle();

    // SRAM contents survive a debug module reset
    sram_write(sram_idx[0], '1, {rand32(), rand32()});
    bus_idle();
    ndmreset_i = 1'b1;
    repeat (3) sram_read(sram_idx[0]);
    ndmreset_i = 1'b0;
    bus_idle();
    wait (sys_rst_n);
    @(negedge clk_i);
    sram_read(sram_idx[0]);
    bus_idle();

    bus_access(1'b0, GPIO_BASE + (64'(rand32()) % GPIO_LENGTH), '1, '0, '0, 1'b0, 1'b1);
    bus_access(1'b1, GPIO_BASE, '1, {rand32(), rand32()}, '0, 1'b0, 1'b1);
    bus_access(1'b0, 64'h0, '1, '0, '0, 1'b0, 1'b1);
    bus_access(1'b0, 64'h3000_0000, '1, '0, '0, 1'b0, 1'b1);
    bus_access(1'b1, DRAM_BASE + SRAM_LENGTH, '1, '0, '0, 1'b0, 1'b1);
    bus_access(1'b0, 64'hFFFF_FFFF_FFFF_FFF8, '1, '0, '0, 1'b0, 1'b1);
    bus_idle();

    bus_access(1'b1, CLINT_BASE + MSIP_OFFSET, 8'h01, 64'h1, '0, 1'b0, 1'b0);
    bus_access(1'b0, CLINT_BASE + MSIP_OFFSET, '1, '0, 64'h1, 1'b1, 1'b0);
    bus_access(1'b1, CLINT_BASE + MSIP_OFFSET, 8'h01, 64'h0, '0, 1'b0, 1'b0);
    bus_access(1'b1, CLINT_BASE + MTIME_OFFSET, '1, MTIME_START, '0, 1'b0, 1'b0);
    bus_access(1'b1, CLINT_BASE + MTIMECMP_OFFSET, '1, MTIME_START + TIMER_DELTA, '0,
               1'b0, 1'b0);
    bus_access(1'b0, CLINT_BASE + MTIMECMP_OFFSET, '1, '0, MTIME_START + TIMER_DELTA,
               1'b1, 1'b0);
    bus_idle();
    while (!timer_irq_o && rtc_rises < MAX_TICKS) rtc_tick();
    if (!timer_irq_o) begin
      report_error("timer_irq_o never rose after mtime reached mtimecmp");
    end
    if (rtc_rises != TIMER_DELTA) begin
      report_error("timer_irq_o rose later than expected");
    end
    bus_access(1'b0, CLINT_BASE + MTIME_OFFSET, '1, '0, MTIME_START + TIMER_DELTA, 1'b1, 1'b0);
    bus_idle();
    rtc_tick();
    bus_access(1'b0, CLINT_BASE + MTIME_OFFSET, '1, '0, MTIME_START + TIMER_DELTA + 1,
               1'b1, 1'b0);
    bus_idle();

    // Debug request released at the end of the hold-off
    wait (debug_req_o);
    @(negedge clk_i);
    debug_enable_i = 1'b0;
    repeat (5) @(negedge clk_i);
    debug_enable_i = 1'b1;
    debug_req_i = 1'b0;
    repeat (2) @(negedge clk_i);

    $display("test passed");
    $finish;
  end

  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles before the tests finished", RUN_CYCLES);
    $display("test failed");
    $fatal(1, "watchdog timeout");
  end

endmodule

// ==== hw/soc_harness.sv ====
// Top level of the simulation SoC harness
// Reset and debug control, address decoder, boot ROM, SRAM and CLINT
module soc_harness (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               rtc_i,
  input  logic                               ndmreset_i,
  input  logic                               debug_enable_i,
  input  logic                               debug_req_i,
  input  logic                               req_i,
  input  logic                               we_i,
  input  logic [harness_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [harness_pkg::BE_WIDTH-1:0]   be_i,
  input  logic [harness_pkg::DATA_WIDTH-1:0] wdata_i,
  output logic                               rvalid_o,
  output logic                               err_o,
  output logic                               ipi_o,
  output logic                               timer_irq_o,
  output logic                               debug_req_o,
  output logic [harness_pkg::DATA_WIDTH-1:0] rdata_o
);
  import harness_pkg::*;

  logic                  sys_rst_n;
  logic                  rom_req;
  logic                  sram_req;
  logic                  clint_req;
  logic [DATA_WIDTH-1:0] rom_rdata;
  logic [DATA_WIDTH-1:0] sram_rdata;
  logic [DATA_WIDTH-1:0] clint_rdata;

  debug_reset_ctrl debug_reset_ctrl_inst (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .ndmreset_i     ( ndmreset_i     ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_i    ( debug_req_i    ),
    .sys_rst_no     ( sys_rst_n      ),
    .debug_req_o    ( debug_req_o    )
  );

  // ------------------------------
  // Memory system
  // ------------------------------
  mem_decoder mem_decoder_inst (
    .clk_i         ( clk_i       ),
    .rst_ni        ( sys_rst_n   ),
    .req_i         ( req_i       ),
    .addr_i        ( addr_i      ),
    .rom_rdata_i   ( rom_rdata   ),
    .sram_rdata_i  ( sram_rdata  ),
    .clint_rdata_i ( clint_rdata ),
    .rom_req_o     ( rom_req     ),
    .sram_req_o    ( sram_req    ),
    .clint_req_o   ( clint_req   ),
    .rvalid_o      ( rvalid_o    ),
    .err_o         ( err_o       ),
    .rdata_o       ( rdata_o     )
  );

  boot_rom boot_rom_inst (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .addr_i  ( addr_i    ),
    .rdata_o ( rom_rdata )
  );

  sram sram_inst (
    .clk_i   ( clk_i      ),
    .req_i   ( sram_req   ),
    .we_i    ( we_i       ),
    .addr_i  ( addr_i     ),
    .be_i    ( be_i       ),
    .wdata_i ( wdata_i    ),
    .rdata_o ( sram_rdata )
  );

  clint clint_inst (
    .clk_i       ( clk_i       ),
    .rst_ni      ( sys_rst_n   ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .be_i        ( be_i        ),
    .wdata_i     ( wdata_i     ),
    .rdata_o     ( clint_rdata ),
    .ipi_o       ( ipi_o       ),
    .timer_irq_o ( timer_irq_o )
  );

endmodule

// ==== hw/clint.sv ====
// Core-local interruptor
// MSIP bit, mtime driven by the real-time clock, mtimecmp
// Software and timer interrupt outputs
module clint (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               rtc_i,
  input  logic                               req_i,
  input  logic                               we_i,
  input  logic [harness_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [harness_pkg::BE_WIDTH-1:0]   be_i,
  input  logic [harness_pkg::DATA_WIDTH-1:0] wdata_i,
  output logic [harness_pkg::DATA_WIDTH-1:0] rdata_o,
  output logic                               ipi_o,
  output logic                               timer_irq_o
);
  import harness_pkg::*;

  logic [ADDR_WIDTH-1:0] reg_offset;
  logic [1:0]            rtc_sync_q;
  logic                  rtc_prev_q;
  logic                  rtc_rise;
  logic                  msip_q;
  logic [DATA_WIDTH-1:0] mtime_q;
  logic [DATA_WIDTH-1:0] mtimecmp_q;
  logic                  timer_irq_q;
  logic                  msip_wr;
  logic                  mtime_wr;
  logic                  mtimecmp_wr;

  function automatic logic [DATA_WIDTH-1:0] merge_be(input logic [DATA_WIDTH-1:0] old_val,
                                                     input logic [DATA_WIDTH-1:0] new_val,
                                                     input logic [BE_WIDTH-1:0]   be);
    logic [DATA_WIDTH-1:0] res;
    res = old_val;
    for (int i = 0; i < BE_WIDTH; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Word-aligned offset inside the window
  assign reg_offset = (addr_i - CLINT_BASE) & ~ADDR_WIDTH'(BE_WIDTH - 1);

  assign msip_wr     = req_i && we_i && (reg_offset == MSIP_OFFSET);
  assign mtimecmp_wr = req_i && we_i && (reg_offset == MTIMECMP_OFFSET);
  assign mtime_wr    = req_i && we_i && (reg_offset == MTIME_OFFSET);

  // ------------------------------
  // RTC edge detect
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q <= 2'b00;
      rtc_prev_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
    end
  end

  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      msip_q      <= 1'b0;
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      timer_irq_q <= 1'b0;
    end else begin
      if (msip_wr && be_i[0]) begin
        msip_q <= wdata_i[0];
      end
      if (mtimecmp_wr) begin
        mtimecmp_q <= merge_be(mtimecmp_q, wdata_i, be_i);
      end
      // A host write wins over a tick in the same cycle
      if (mtime_wr) begin
        mtime_q <= merge_be(mtime_q, wdata_i, be_i);
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + 1'b1;
      end
      timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (reg_offset)
        MSIP_OFFSET:     rdata_o <= {{(DATA_WIDTH-1){1'b0}}, msip_q};
        MTIMECMP_OFFSET: rdata_o <= mtimecmp_q;
        MTIME_OFFSET:    rdata_o <= mtime_q;
        default:         rdata_o <= '0;
      endcase
    end
  end

  assign ipi_o       = msip_q;
  assign timer_irq_o = timer_irq_q;

  a_mtime_monotonic: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !mtime_wr |=> (mtime_q >= $past(mtime_q))
  ) else $error("mtime decreased without a write");

endmodule

// ==== hw/sram.sv ====
// Single-port SRAM behind the DRAM window
// Byte-enabled writes, one-cycle registered read
module sram (
  input  logic                               clk_i,
  input  logic                               req_i,
  input  logic                               we_i,
  input  logic [harness_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [harness_pkg::BE_WIDTH-1:0]   be_i,
  input  logic [harness_pkg::DATA_WIDTH-1:0] wdata_i,
  output logic [harness_pkg::DATA_WIDTH-1:0] rdata_o
);
  import harness_pkg::*;

  logic [DATA_WIDTH-1:0]    mem_q [SRAM_WORDS];
  logic [SRAM_IDX_BITS-1:0] word_idx;

  // Word index wraps inside the window
  assign word_idx = addr_i[WORD_OFFSET_BITS +: SRAM_IDX_BITS];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int i = 0; i < BE_WIDTH; i++) begin
          if (be_i[i]) begin
            mem_q[word_idx][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[word_idx];
      end
    end
  end

endmodule

// ==== hw/boot_rom.sv ====
// Boot ROM with generated contents
// Each word carries the ROM tag above its own word index
module boot_rom (
  input  logic                               clk_i,
  input  logic                               req_i,
  input  logic [harness_pkg::ADDR_WIDTH-1:0] addr_i,
  output logic [harness_pkg::DATA_WIDTH-1:0] rdata_o
);
  import harness_pkg::*;

  localparam int unsigned PAD_BITS = DATA_WIDTH - $bits(ROM_TAG) - ROM_IDX_BITS;

  logic [ROM_IDX_BITS-1:0] word_idx;

  // Index wraps inside the window
  assign word_idx = addr_i[WORD_OFFSET_BITS +: ROM_IDX_BITS];

  function automatic logic [DATA_WIDTH-1:0] rom_word(input logic [ROM_IDX_BITS-1:0] idx);
    return {ROM_TAG, {PAD_BITS{1'b0}}, idx};
  endfunction

  // Writes land here too and simply read back the fixed word
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rom_word(word_idx);
    end
  end

endmodule

// ==== hw/mem_decoder.sv ====
// Address decoder for the host bus
// Per-target request strobes, registered target select,
// read data multiplexer and error flag for GPIO and unmapped addresses
module mem_decoder (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               req_i,
  input  logic [harness_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [harness_pkg::DATA_WIDTH-1:0] rom_rdata_i,
  input  logic [harness_pkg::DATA_WIDTH-1:0] sram_rdata_i,
  input  logic [harness_pkg::DATA_WIDTH-1:0] clint_rdata_i,
  output logic                               rom_req_o,
  output logic                               sram_req_o,
  output logic                               clint_req_o,
  output logic                               rvalid_o,
  output logic                               err_o,
  output logic [harness_pkg::DATA_WIDTH-1:0] rdata_o
);
  import harness_pkg::*;

  logic [TARGET_BITS-1:0] target_sel;
  logic [TARGET_BITS-1:0] target_q;
  logic                   rvalid_q;

  function automatic logic in_window(input logic [ADDR_WIDTH-1:0] addr,
                                     input logic [ADDR_WIDTH-1:0] base,
                                     input logic [ADDR_WIDTH-1:0] length);
    return (addr >= base) && (addr < base + length);
  endfunction

  always_comb begin
    if (in_window(addr_i, ROM_BASE, ROM_LENGTH)) begin
      target_sel = TARGET_ROM;
    end else if (in_window(addr_i, CLINT_BASE, CLINT_LENGTH)) begin
      target_sel = TARGET_CLINT;
    end else if (in_window(addr_i, DRAM_BASE, SRAM_LENGTH)) begin
      target_sel = TARGET_SRAM;
    end else begin
      // GPIO window and unmapped addresses, no block behind them
      target_sel = TARGET_ERR;
    end
  end

  assign rom_req_o   = req_i && (target_sel == TARGET_ROM);
  assign sram_req_o  = req_i && (target_sel == TARGET_SRAM);
  assign clint_req_o = req_i && (target_sel == TARGET_CLINT);

  // ------------------------------
  // Response path
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      target_q <= TARGET_ERR;
    end else begin
      rvalid_q <= req_i;
      if (req_i) begin
        target_q <= target_sel;
      end
    end
  end

  always_comb begin
    case (target_q)
      TARGET_ROM:   rdata_o = rom_rdata_i;
      TARGET_SRAM:  rdata_o = sram_rdata_i;
      TARGET_CLINT: rdata_o = clint_rdata_i;
      default:      rdata_o = '0;
    endcase
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = rvalid_q && (target_q == TARGET_ERR);

  // Windows of the address map never overlap
  a_one_target: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_i |-> $onehot0({in_window(addr_i, ROM_BASE, ROM_LENGTH),
                        in_window(addr_i, CLINT_BASE, CLINT_LENGTH),
                        in_window(addr_i, DRAM_BASE, SRAM_LENGTH),
                        in_window(addr_i, GPIO_BASE, GPIO_LENGTH)})
  ) else $error("address hits more than one window");

endmodule

// ==== hw/debug_reset_ctrl.sv ====
// System reset generation from power-on reset and debug module reset
// Debug request hold-off counter and enable gate
module debug_reset_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic debug_enable_i,
  input  logic debug_req_i,
  output logic sys_rst_no,
  output logic debug_req_o
);
  import harness_pkg::*;

  logic                    rst_comb_n;
  logic [1:0]              rst_sync_q;
  logic [DMI_CNT_BITS-1:0] dmi_del_cnt_q;
  logic                    dmi_del_done;

  // ------------------------------
  // Reset synchronizer
  // ------------------------------
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  // Asserts at once, releases after two clock edges
  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = rst_sync_q[1];

  // ------------------------------
  // Debug request gate
  // ------------------------------
  assign dmi_del_done = (dmi_del_cnt_q == '0);

  // Only power-on reset restarts the hold-off
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmi_del_cnt_q <= DMI_CNT_BITS'(DMI_DEL_CYCLES);
    end else if (!dmi_del_done) begin
      dmi_del_cnt_q <= dmi_del_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = dmi_del_done & debug_enable_i & debug_req_i;

  // Blocked for the whole hold-off after power-on reset
  a_no_debug_in_holdoff: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    debug_req_o |-> $past(rst_ni, DMI_DEL_CYCLES)
  ) else $error("debug request passed during hold-off");

endmodule

// ==== hw/harness_pkg.sv ====
// Shared constants for the simulation SoC harness
// Bus widths, address map and memory sizes
// CLINT register offsets and decoder target indices
// Debug request hold-off after power-on reset
package harness_pkg;

  // ------------------------------
  // Host bus
  // ------------------------------
  localparam int unsigned ADDR_WIDTH       = 64;
  localparam int unsigned DATA_WIDTH       = 64;
  localparam int unsigned BE_WIDTH         = DATA_WIDTH / 8;
  localparam int unsigned WORD_OFFSET_BITS = $clog2(BE_WIDTH);

  // ------------------------------
  // Address map
  // ------------------------------
  localparam logic [ADDR_WIDTH-1:0] ROM_BASE     = 64'h0000_0000_0001_0000;
  localparam logic [ADDR_WIDTH-1:0] ROM_LENGTH   = 64'h0000_0000_0001_0000;
  localparam logic [ADDR_WIDTH-1:0] CLINT_BASE   = 64'h0000_0000_0200_0000;
  localparam logic [ADDR_WIDTH-1:0] CLINT_LENGTH = 64'h0000_0000_000C_0000;
  localparam logic [ADDR_WIDTH-1:0] GPIO_BASE    = 64'h0000_0000_4000_0000;
  localparam logic [ADDR_WIDTH-1:0] GPIO_LENGTH  = 64'h0000_0000_0000_1000;
  localparam logic [ADDR_WIDTH-1:0] DRAM_BASE    = 64'h0000_0000_8000_0000;

  // Boot ROM contents are generated, words wrap inside the window
  localparam int unsigned ROM_WORDS    = 512;
  localparam int unsigned ROM_IDX_BITS = $clog2(ROM_WORDS);
  localparam logic [31:0] ROM_TAG      = 32'hB007_C0DE;

  localparam int unsigned SRAM_WORDS    = 1024;
  localparam int unsigned SRAM_IDX_BITS = $clog2(SRAM_WORDS);
  localparam logic [ADDR_WIDTH-1:0] SRAM_LENGTH = ADDR_WIDTH'(SRAM_WORDS * BE_WIDTH);

  // ------------------------------
  // CLINT registers
  // ------------------------------
  localparam logic [ADDR_WIDTH-1:0] MSIP_OFFSET     = 64'h0000;
  localparam logic [ADDR_WIDTH-1:0] MTIMECMP_OFFSET = 64'h4000;
  localparam logic [ADDR_WIDTH-1:0] MTIME_OFFSET    = 64'hBFF8;

  // Decoder targets
  localparam int unsigned TARGET_BITS = 2;
  localparam logic [TARGET_BITS-1:0] TARGET_ROM   = 2'd0;
  localparam logic [TARGET_BITS-1:0] TARGET_SRAM  = 2'd1;
  localparam logic [TARGET_BITS-1:0] TARGET_CLINT = 2'd2;
  localparam logic [TARGET_BITS-1:0] TARGET_ERR   = 2'd3;

  // Gives boot code time to run before debug can halt the hart
  localparam int unsigned DMI_DEL_CYCLES = 500;
  localparam int unsigned DMI_CNT_BITS   = $clog2(DMI_DEL_CYCLES + 1);

endpackage
